//--- pmp_pkg.sv
// PMP shared definitions
package pmp_pkg;

   // ----------------------------------------
   // Sizes and CSR map
   // ----------------------------------------

   // Number of PMP entries
   localparam int pmp_entries = 16;

   // First pmpcfg CSR, groups 0 to 3 follow it
   localparam logic [11:0] csr_pmpcfg_base = 12'h3a0;

   // First pmpaddr CSR, entries 0 to 15 follow it
   localparam logic [11:0] csr_pmpaddr_base = 12'h3b0;

   // ----------------------------------------
   // Fields of one cfg byte
   // ----------------------------------------

   // Read permission
   localparam int r_bit = 0;
   // Write permission
   localparam int w_bit = 1;
   // Execute permission
   localparam int x_bit = 2;
   // Lock, also binds machine mode
   localparam int l_bit = 7;

   // Address matching mode, the A field in bits 4:3
   typedef enum logic [1:0] {
      mode_off   = 2'd0,
      mode_tor   = 2'd1,
      mode_na4   = 2'd2,
      mode_napot = 2'd3
   } pmp_mode_e;

   // ----------------------------------------
   // Check request attributes
   // ----------------------------------------

   // Kind of access being checked
   typedef enum logic [1:0] {
      acc_read  = 2'd0,
      acc_write = 2'd1,
      acc_exec  = 2'd2
   } pmp_access_e;

   // Privilege of the requester
   typedef enum logic {
      priv_user    = 1'b0,
      priv_machine = 1'b1
   } pmp_priv_e;

endpackage

//--- pmp_csr_ctrl.sv
// PMP CSR address decode
`timescale 1ns/1ps

module pmp_csr_ctrl (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        csr_wen,
   input  logic [11:0] csr_waddr,
   input  logic [31:0] csr_wdata,
   input  logic [11:0] csr_raddr,
   input  logic [31:0] rd_data,
   output logic        cfg_we,
   output logic        addr_we,
   output logic [3:0]  wr_index,
   output logic [31:0] wr_data,
   output logic        rd_cfg_sel,
   output logic        rd_addr_sel,
   output logic [3:0]  rd_index,
   output logic [31:0] csr_rdata,
   output logic        csr_hit
);

   import pmp_pkg::*;

   logic        wr_cfg_hit;
   logic        wr_addr_hit;

   // ----------------------------------------
   // Write decode
   // ----------------------------------------

   // Only pmpcfg0 to pmpcfg3 exist in the 3Ax block
   assign wr_cfg_hit = (csr_waddr[11:4] == csr_pmpcfg_base[11:4])
                     && (csr_waddr[3:2] == 2'b00);
   // All sixteen pmpaddr registers in the 3Bx block
   assign wr_addr_hit = (csr_waddr[11:4] == csr_pmpaddr_base[11:4]);

   assign cfg_we   = csr_wen && wr_cfg_hit;
   assign addr_we  = csr_wen && wr_addr_hit;
   // Group number sits in the low 2 bits for cfg writes
   assign wr_index = csr_waddr[3:0];
   assign wr_data  = csr_wdata;

   // ----------------------------------------
   // Read decode
   // ----------------------------------------

   assign rd_cfg_sel  = (csr_raddr[11:4] == csr_pmpcfg_base[11:4])
                      && (csr_raddr[3:2] == 2'b00);
   assign rd_addr_sel = (csr_raddr[11:4] == csr_pmpaddr_base[11:4]);
   assign rd_index    = csr_raddr[3:0];
   assign csr_hit     = rd_cfg_sel || rd_addr_sel;

   // Unmapped addresses read as zero
   assign csr_rdata = csr_hit ? rd_data : 32'h0000_0000;

endmodule

//--- pmp_cfg_regs.sv
// PMP configuration registers
`timescale 1ns/1ps

module pmp_cfg_regs (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cfg_we,
   input  logic        addr_we,
   input  logic [3:0]  wr_index,
   input  logic [31:0] wr_data,
   input  logic        rd_cfg_sel,
   input  logic        rd_addr_sel,
   input  logic [3:0]  rd_index,
   output logic [31:0] rd_data,
   output logic [7:0]  cfg_bytes [pmp_pkg::pmp_entries],
   output logic [31:0] addr_regs [pmp_pkg::pmp_entries]
);

   import pmp_pkg::*;

   logic [pmp_entries-1:0] lock;
   logic [pmp_entries-1:0] next_tor_lock;
   logic [pmp_entries-1:0] cfg_wr_en;
   logic [pmp_entries-1:0] addr_wr_en;
   logic [1:0]             rd_group;
   logic [31:0]            cfg_word;

   // WARL filter for one cfg byte
   function automatic logic [7:0] cfg_warl(input logic [7:0] raw);
      logic [7:0] val;
      // Bits 6:5 reserved
      val = raw & 8'h9f;
      // R=0 with W=1 is illegal
      if (!val[r_bit]) begin
         val[w_bit] = 1'b0;
      end
      return val;
   endfunction

   // ----------------------------------------
   // Per-entry lock and write enables
   // ----------------------------------------

   for (genvar i = 0; i < pmp_entries; i++) begin : g_entry
      localparam logic [3:0] entry_idx = 4'(i);

      assign lock[i] = cfg_bytes[i][l_bit];

      // Locked TOR entry above also guards this address
      if (i + 1 < pmp_entries) begin : g_next
         assign next_tor_lock[i] = cfg_bytes[i+1][l_bit]
            && (pmp_mode_e'(cfg_bytes[i+1][4:3]) == mode_tor);
      end else begin : g_last
         assign next_tor_lock[i] = 1'b0;
      end

      // Four bytes per cfg group
      assign cfg_wr_en[i]  = cfg_we && (wr_index[1:0] == entry_idx[3:2]) && !lock[i];
      assign addr_wr_en[i] = addr_we && (wr_index == entry_idx)
                           && !lock[i] && !next_tor_lock[i];
   end

   // ----------------------------------------
   // Storage
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < pmp_entries; i++) begin
            cfg_bytes[i] <= 8'h00;
            addr_regs[i] <= 32'h0;
         end
      end else begin
         for (int i = 0; i < pmp_entries; i++) begin
            if (cfg_wr_en[i]) begin
               cfg_bytes[i] <= cfg_warl(wr_data[8*(i%4) +: 8]);
            end
            if (addr_wr_en[i]) begin
               // Upper two address bits do not exist
               addr_regs[i] <= {2'b00, wr_data[29:0]};
            end
         end
      end
   end

   // ----------------------------------------
   // CSR read mux
   // ----------------------------------------

   assign rd_group = rd_index[1:0];

   // Entry 4g+3 in the top byte
   assign cfg_word = {cfg_bytes[{rd_group, 2'd3}],
                      cfg_bytes[{rd_group, 2'd2}],
                      cfg_bytes[{rd_group, 2'd1}],
                      cfg_bytes[{rd_group, 2'd0}]};

   assign rd_data = rd_cfg_sel  ? cfg_word :
                    rd_addr_sel ? addr_regs[rd_index] : 32'h0000_0000;

endmodule

//--- pmp_region_match.sv
// PMP region address match
`timescale 1ns/1ps

module pmp_region_match (
   input  logic [7:0]                       cfg_bytes [pmp_pkg::pmp_entries],
   input  logic [31:0]                      addr_regs [pmp_pkg::pmp_entries],
   input  logic [31:0]                      chk_addr,
   output logic [pmp_pkg::pmp_entries-1:0]  match_vec
);

   import pmp_pkg::*;

   logic [31:0] word_addr;

   // pmpaddr holds address bits 33:2, so compare in words
   assign word_addr = {2'b00, chk_addr[31:2]};

   for (genvar i = 0; i < pmp_entries; i++) begin : g_entry
      pmp_mode_e   mode;
      logic [31:0] lo_bound;
      logic [31:0] napot_mask;
      logic        tor_hit;
      logic        na4_hit;
      logic        napot_hit;

      assign mode = pmp_mode_e'(cfg_bytes[i][4:3]);

      // ----------------------------------------
      // TOR bounds
      // ----------------------------------------

      // Entry 0 starts at address zero
      if (i == 0) begin : g_first
         assign lo_bound = 32'h0000_0000;
      end else begin : g_prev
         assign lo_bound = addr_regs[i-1];
      end

      // Lower bound inclusive, top exclusive
      assign tor_hit = (word_addr >= lo_bound) && (word_addr < addr_regs[i]);

      // ----------------------------------------
      // Naturally aligned regions
      // ----------------------------------------

      // Exactly one word
      assign na4_hit = (word_addr == addr_regs[i]);

      // Trailing ones plus the zero above them give the size,
      // so those low bits are don't care
      assign napot_mask = ~(addr_regs[i] ^ (addr_regs[i] + 32'd1));
      assign napot_hit  = ((word_addr ^ addr_regs[i]) & napot_mask) == 32'h0000_0000;

      // OFF never matches
      assign match_vec[i] = (mode == mode_tor)   ? tor_hit :
                            (mode == mode_na4)   ? na4_hit :
                            (mode == mode_napot) ? napot_hit : 1'b0;
   end

endmodule

//--- pmp_access_check.sv
// PMP permission check
`timescale 1ns/1ps

module pmp_access_check (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             chk_valid,
   input  pmp_pkg::pmp_access_e             chk_access,
   input  pmp_pkg::pmp_priv_e               chk_priv,
   input  logic [7:0]                       cfg_bytes [pmp_pkg::pmp_entries],
   input  logic [pmp_pkg::pmp_entries-1:0]  match_vec,
   output logic                             chk_done,
   output logic                             chk_fault
);

   import pmp_pkg::*;

   logic       hit;
   logic [7:0] hit_cfg;
   logic       perm;
   logic       allow;

   // ----------------------------------------
   // Priority select
   // ----------------------------------------

   // Walk downwards so the lowest matching entry is kept
   always_comb begin
      hit     = 1'b0;
      hit_cfg = 8'h00;
      for (int i = pmp_entries - 1; i >= 0; i--) begin
         if (match_vec[i]) begin
            hit     = 1'b1;
            hit_cfg = cfg_bytes[i];
         end
      end
   end

   // ----------------------------------------
   // Permission decision
   // ----------------------------------------

   always_comb begin
      case (chk_access)
         acc_read:  perm = hit_cfg[r_bit];
         acc_write: perm = hit_cfg[w_bit];
         acc_exec:  perm = hit_cfg[x_bit];
         default:   perm = 1'b0;
      endcase

      if (!hit) begin
         // No region: only machine mode passes
         allow = (chk_priv == priv_machine);
      end else if (!hit_cfg[l_bit] && (chk_priv == priv_machine)) begin
         // Unlocked entries do not bind machine mode
         allow = 1'b1;
      end else begin
         allow = perm;
      end
   end

   // Result one cycle after the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         chk_done <= 1'b0;
      end else begin
         chk_done <= chk_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (chk_valid) begin
         chk_fault <= !allow;
      end
   end

endmodule

//--- pmp_unit.sv
// PMP unit top level
`timescale 1ns/1ps

module pmp_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   // CSR side
   input  logic                  csr_wen,
   input  logic [11:0]           csr_waddr,
   input  logic [31:0]           csr_wdata,
   input  logic [11:0]           csr_raddr,
   output logic [31:0]           csr_rdata,
   output logic                  csr_hit,
   // Check side
   input  logic                  chk_valid,
   input  logic [31:0]           chk_addr,
   input  pmp_pkg::pmp_access_e  chk_access,
   input  pmp_pkg::pmp_priv_e    chk_priv,
   output logic                  chk_done,
   output logic                  chk_fault
);

   import pmp_pkg::*;

   // ----------------------------------------
   // Internal nets
   // ----------------------------------------

   // Decoded CSR write
   logic                   cfg_we;
   logic                   addr_we;
   logic [3:0]             wr_index;
   logic [31:0]            wr_data;
   // Decoded CSR read
   logic                   rd_cfg_sel;
   logic                   rd_addr_sel;
   logic [3:0]             rd_index;
   logic [31:0]            rd_data;
   // Register state to the check path
   logic [7:0]             cfg_bytes [pmp_entries];
   logic [31:0]            addr_regs [pmp_entries];
   logic [pmp_entries-1:0] match_vec;

   // CSR decode
   pmp_csr_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .csr_wen     (csr_wen),
      .csr_waddr   (csr_waddr),
      .csr_wdata   (csr_wdata),
      .csr_raddr   (csr_raddr),
      .rd_data     (rd_data),
      .cfg_we      (cfg_we),
      .addr_we     (addr_we),
      .wr_index    (wr_index),
      .wr_data     (wr_data),
      .rd_cfg_sel  (rd_cfg_sel),
      .rd_addr_sel (rd_addr_sel),
      .rd_index    (rd_index),
      .csr_rdata   (csr_rdata),
      .csr_hit     (csr_hit)
   );

   // cfg and address storage
   pmp_cfg_regs u_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_we      (cfg_we),
      .addr_we     (addr_we),
      .wr_index    (wr_index),
      .wr_data     (wr_data),
      .rd_cfg_sel  (rd_cfg_sel),
      .rd_addr_sel (rd_addr_sel),
      .rd_index    (rd_index),
      .rd_data     (rd_data),
      .cfg_bytes   (cfg_bytes),
      .addr_regs   (addr_regs)
   );

   // Region match per entry
   pmp_region_match u_match (
      .cfg_bytes (cfg_bytes),
      .addr_regs (addr_regs),
      .chk_addr  (chk_addr),
      .match_vec (match_vec)
   );

   // Priority, permission and result register
   pmp_access_check u_check (
      .clk        (clk),
      .rst_n      (rst_n),
      .chk_valid  (chk_valid),
      .chk_access (chk_access),
      .chk_priv   (chk_priv),
      .cfg_bytes  (cfg_bytes),
      .match_vec  (match_vec),
      .chk_done   (chk_done),
      .chk_fault  (chk_fault)
   );

endmodule

//--- pmp_unit_chk.sv
// PMP unit assertions
`timescale 1ns/1ps

module pmp_unit_chk (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        chk_valid,
   input  logic        chk_done,
   input  logic [11:0] csr_raddr,
   input  logic        csr_hit,
   input  logic [7:0]  cfg_bytes [pmp_pkg::pmp_entries],
   input  logic [31:0] addr_regs [pmp_pkg::pmp_entries]
);

   import pmp_pkg::*;

   int   fail_count = 0;
   logic raddr_mapped;

   // pmpcfg0 to pmpcfg3 and pmpaddr0 to pmpaddr15
   assign raddr_mapped = (csr_raddr[11:2] == csr_pmpcfg_base[11:2])
                       || (csr_raddr[11:4] == csr_pmpaddr_base[11:4]);

   // ----------------------------------------
   // Check path timing
   // ----------------------------------------

   done_timing: assert property (@(posedge clk) disable iff (!rst_n)
      chk_done == $past(chk_valid))
      else begin
         $error("chk_done not exactly one cycle after chk_valid");
         fail_count++;
      end

   done_reset: assert property (@(posedge clk) !rst_n |=> !chk_done)
      else begin
         $error("chk_done high after reset");
         fail_count++;
      end

   hit_decode: assert property (@(posedge clk) csr_hit == raddr_mapped)
      else begin
         $error("csr_hit disagrees with the PMP CSR map");
         fail_count++;
      end

   // ----------------------------------------
   // Per-entry register rules
   // ----------------------------------------

   for (genvar i = 0; i < pmp_entries; i++) begin : g_entry
      lock_hold: assert property (@(posedge clk) disable iff (!rst_n)
         $past(cfg_bytes[i][l_bit]) |-> cfg_bytes[i] == $past(cfg_bytes[i]))
         else begin
            $error("locked cfg byte changed");
            fail_count++;
         end

      addr_top_zero: assert property (@(posedge clk) addr_regs[i][31:30] == 2'b00)
         else begin
            $error("pmpaddr bits 31:30 not zero");
            fail_count++;
         end
   end

endmodule

//--- tb_pmp_unit.sv
// PMP unit testbench
`timescale 1ns/1ps

module tb_pmp_unit;

   import pmp_pkg::*;

   localparam int clk_period  = 100;
   // About 200 cycles of tests, rounded up
   localparam int test_cycles = 250;
   localparam int margin_ns   = 5000;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        csr_wen;
   logic [11:0] csr_waddr;
   logic [31:0] csr_wdata;
   logic [11:0] csr_raddr;
   logic [31:0] csr_rdata;
   logic        csr_hit;
   logic        chk_valid;
   logic [31:0] chk_addr;
   pmp_access_e chk_access;
   pmp_priv_e   chk_priv;
   logic        chk_done;
   logic        chk_fault;

   // Reference copy of the PMP registers
   logic [7:0]  cfg_m [pmp_entries];
   logic [31:0] addr_m [pmp_entries];
   // Predicted faults of requests in flight
   logic        exp_q [$];
   logic        want_fault;
   int          seed = 32'h40c70e3b;
   int          errors = 0;
   int          checks = 0;
   int          tests_run = 0;

   always #(clk_period / 2) clk = ~clk;

   pmp_unit u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .csr_wen    (csr_wen),
      .csr_waddr  (csr_waddr),
      .csr_wdata  (csr_wdata),
      .csr_raddr  (csr_raddr),
      .csr_rdata  (csr_rdata),
      .csr_hit    (csr_hit),
      .chk_valid  (chk_valid),
      .chk_addr   (chk_addr),
      .chk_access (chk_access),
      .chk_priv   (chk_priv),
      .chk_done   (chk_done),
      .chk_fault  (chk_fault)
   );

   bind pmp_unit pmp_unit_chk u_chk (
      .clk       (clk),
      .rst_n     (rst_n),
      .chk_valid (chk_valid),
      .chk_done  (chk_done),
      .csr_raddr (csr_raddr),
      .csr_hit   (csr_hit),
      .cfg_bytes (cfg_bytes),
      .addr_regs (addr_regs)
   );

   // ----------------------------------------
   // Reference model
   // ----------------------------------------

   // Reserved bits cleared, W dropped without R
   function automatic logic [7:0] mask_cfg(input logic [7:0] raw);
      logic [7:0] val;
      val = {raw[7], 2'b00, raw[4:0]};
      if (!val[r_bit]) begin
         val[w_bit] = 1'b0;
      end
      return val;
   endfunction

   function automatic void clear_model();
      for (int i = 0; i < pmp_entries; i++) begin
         cfg_m[i]  = 8'h00;
         addr_m[i] = 32'h0;
      end
   endfunction

   function automatic void update_model(input logic [11:0] wa, input logic [31:0] wd);
      int   g;
      int   e;
      logic locked;
      if (wa[11:2] == csr_pmpcfg_base[11:2]) begin
         g = int'(wa[1:0]);
         for (int j = 0; j < 4; j++) begin
            if (!cfg_m[4*g+j][l_bit]) begin
               cfg_m[4*g+j] = mask_cfg(wd[8*j +: 8]);
            end
         end
      end else if (wa[11:4] == csr_pmpaddr_base[11:4]) begin
         e = int'(wa[3:0]);
         locked = cfg_m[e][l_bit];
         // Locked TOR entry above guards its lower bound
         if (e < pmp_entries - 1) begin
            if (cfg_m[e+1][l_bit] && pmp_mode_e'(cfg_m[e+1][4:3]) == mode_tor) begin
               locked = 1'b1;
            end
         end
         if (!locked) begin
            addr_m[e] = {2'b00, wd[29:0]};
         end
      end
   endfunction

   // Hit flag on top of the read data
   function automatic logic [32:0] predict_read(input logic [11:0] ra);
      int g;
      if (ra[11:2] == csr_pmpcfg_base[11:2]) begin
         g = int'(ra[1:0]);
         return {1'b1, cfg_m[4*g+3], cfg_m[4*g+2], cfg_m[4*g+1], cfg_m[4*g]};
      end
      if (ra[11:4] == csr_pmpaddr_base[11:4]) begin
         return {1'b1, addr_m[ra[3:0]]};
      end
      return 33'd0;
   endfunction

   function automatic logic predict_fault(input logic [31:0] a, input pmp_access_e acc,
                                          input pmp_priv_e pv);
      logic [31:0] word;
      logic [31:0] lo;
      logic [7:0]  c;
      logic        hit;
      logic        found;
      int          t;
      word  = {2'b00, a[31:2]};
      found = 1'b0;
      c     = 8'h00;
      for (int i = 0; i < pmp_entries; i++) begin
         lo = 32'h0;
         if (i > 0) begin
            lo = addr_m[i-1];
         end
         hit = 1'b0;
         case (pmp_mode_e'(cfg_m[i][4:3]))
            mode_tor: hit = (word >= lo) && (word < addr_m[i]);
            mode_na4: hit = (word == addr_m[i]);
            mode_napot: begin
               // t trailing ones give a region of 2^(t+1) words
               t = 0;
               while (t < 32 && addr_m[i][t]) begin
                  t++;
               end
               hit = (word >> (t + 1)) == (addr_m[i] >> (t + 1));
            end
            default: hit = 1'b0;
         endcase
         if (hit && !found) begin
            found = 1'b1;
            c     = cfg_m[i];
         end
      end
      if (!found) begin
         return pv == priv_user;
      end
      if (!c[l_bit] && pv == priv_machine) begin
         return 1'b0;
      end
      case (acc)
         acc_read:  return !c[r_bit];
         acc_write: return !c[w_bit];
         acc_exec:  return !c[x_bit];
         default:   return 1'b1;
      endcase
   endfunction

   function automatic pmp_access_e pick_access(input logic [1:0] bits);
      return (bits == 2'd3) ? acc_read : pmp_access_e'(bits);
   endfunction

   // ----------------------------------------
   // Bus tasks
   // ----------------------------------------

   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      clear_model();
   endtask

   task automatic csr_write(input logic [11:0] wa, input logic [31:0] wd);
      @(posedge clk);
      csr_wen   <= 1'b1;
      csr_waddr <= wa;
      csr_wdata <= wd;
      @(posedge clk);
      csr_wen   <= 1'b0;
      update_model(wa, wd);
   endtask

   task automatic read_compare(input logic [11:0] ra);
      logic [32:0] exp;
      exp = predict_read(ra);
      @(posedge clk);
      csr_raddr <= ra;
      @(negedge clk);
      checks++;
      assert (csr_hit == exp[32] && csr_rdata == exp[31:0]) else begin
         errors++;
         $display("error at %0t ns: CSR %h read hit=%b data=%h, expected hit=%b data=%h",
                  $time, ra, csr_hit, csr_rdata, exp[32], exp[31:0]);
      end
   endtask

   task automatic send_request(input logic [31:0] a, input pmp_access_e acc,
                               input pmp_priv_e pv);
      @(posedge clk);
      chk_valid  <= 1'b1;
      chk_addr   <= a;
      chk_access <= acc;
      chk_priv   <= pv;
      exp_q.push_back(predict_fault(a, acc, pv));
   endtask

   task automatic drain_requests();
      @(posedge clk);
      chk_valid <= 1'b0;
      repeat (2) @(negedge clk);
      if (exp_q.size() != 0) begin
         errors++;
         $display("no chk_done seen for %0d requests by %0t ns", exp_q.size(), $time);
         exp_q.delete();
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      tests_run++;
      if (errors == start_errors) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - start_errors);
      end
   endtask

   // Results come back in request order
   always @(negedge clk) begin
      if (rst_n && chk_done) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("chk_done at %0t ns with no request pending", $time);
         end else begin
            want_fault = exp_q.pop_front();
            checks++;
            assert (chk_fault == want_fault) else begin
               errors++;
               $display("error at %0t ns: chk_fault=%b, expected %b",
                        $time, chk_fault, want_fault);
            end
         end
      end
   end

   // ----------------------------------------
   // Tests
   // ----------------------------------------

   task automatic run_csr_test();
      int          start;
      logic [31:0] r;
      logic [11:0] wa;
      logic [31:0] wd;
      start = errors;
      for (int k = 0; k < 24; k++) begin
         r = $random(seed);
         if (r[8]) begin
            // Keep L clear so later writes still land
            wa = csr_pmpcfg_base | {10'd0, r[1:0]};
            wd = $random(seed) & 32'h7f7f7f7f;
         end else begin
            wa = csr_pmpaddr_base | {8'd0, r[3:0]};
            wd = $random(seed);
         end
         csr_write(wa, wd);
         read_compare(wa);
      end
      // R=0 W=1 bytes and reserved bits
      csr_write(csr_pmpcfg_base | 12'd2, 32'h0266_7f02);
      read_compare(csr_pmpcfg_base | 12'd2);
      read_compare(12'h3a4);
      read_compare(12'h3af);
      read_compare(12'h3c0);
      read_compare(12'h000);
      read_compare(12'h7b0);
      report_test("csr_rw", start);
   endtask

   task automatic run_lock_test();
      int start;
      start = errors;
      apply_reset();
      csr_write(csr_pmpaddr_base | 12'd4, 32'h0000_0040);
      csr_write(csr_pmpaddr_base | 12'd5, 32'h0000_0080);
      // Entry 5 becomes locked TOR with R
      csr_write(csr_pmpcfg_base | 12'd1, 32'h0000_8900);
      csr_write(csr_pmpcfg_base | 12'd1, 32'h1f1f1f1f);
      csr_write(csr_pmpaddr_base | 12'd5, 32'h0000_dead);
      csr_write(csr_pmpaddr_base | 12'd4, 32'h0000_beef);
      csr_write(csr_pmpaddr_base | 12'd6, 32'hc000_1234);
      read_compare(csr_pmpcfg_base | 12'd1);
      read_compare(csr_pmpaddr_base | 12'd4);
      read_compare(csr_pmpaddr_base | 12'd5);
      read_compare(csr_pmpaddr_base | 12'd6);
      apply_reset();
      report_test("lock", start);
   endtask

   task automatic run_region_test();
      int          start;
      logic [31:0] r;
      start = errors;
      // TOR below 0x400, NA4 at 0x2000, NAPOT 32 bytes at 0x4000
      csr_write(csr_pmpaddr_base | 12'd0, 32'h0000_0100);
      csr_write(csr_pmpaddr_base | 12'd2, 32'h0000_0800);
      csr_write(csr_pmpaddr_base | 12'd3, 32'h0000_1003);
      csr_write(csr_pmpcfg_base, 32'h1917_0009);
      send_request(32'h0000_03fc, acc_read, priv_user);
      send_request(32'h0000_0400, acc_read, priv_user);
      send_request(32'h0000_2000, acc_write, priv_user);
      send_request(32'h0000_2004, acc_write, priv_user);
      send_request(32'h0000_1ffc, acc_read, priv_user);
      send_request(32'h0000_4000, acc_read, priv_user);
      send_request(32'h0000_401c, acc_read, priv_user);
      send_request(32'h0000_4020, acc_read, priv_user);
      send_request(32'h0000_3ffc, acc_read, priv_user);
      for (int k = 0; k < 8; k++) begin
         r = $random(seed);
         send_request(r & 32'h0000_7ffc, pick_access(r[17:16]), pmp_priv_e'(r[18]));
      end
      drain_requests();
      report_test("region", start);
   endtask

   task automatic run_priority_test();
      int start;
      start = errors;
      // Entry 0 NAPOT 256 bytes R, entry 1 locked NAPOT 4 KiB RW, both at 0x8000
      csr_write(csr_pmpaddr_base | 12'd0, 32'h0000_201f);
      csr_write(csr_pmpaddr_base | 12'd1, 32'h0000_21ff);
      csr_write(csr_pmpcfg_base, 32'h0000_9b19);
      send_request(32'h0000_8010, acc_write, priv_user);
      send_request(32'h0000_8010, acc_read, priv_user);
      send_request(32'h0000_8100, acc_write, priv_user);
      send_request(32'h0000_8010, acc_write, priv_machine);
      send_request(32'h0000_8100, acc_exec, priv_machine);
      send_request(32'h0000_8100, acc_read, priv_machine);
      send_request(32'h0002_0000, acc_read, priv_machine);
      send_request(32'h0002_0000, acc_read, priv_user);
      drain_requests();
      report_test("priority", start);
   endtask

   task automatic run_pipeline_test();
      int          start;
      logic [31:0] r;
      logic [31:0] a;
      start = errors;
      for (int k = 0; k < 16; k++) begin
         r = $random(seed);
         case (r[5:4])
            2'd0:    a = 32'h0000_8010;
            2'd1:    a = 32'h0000_8100;
            2'd2:    a = 32'h0002_0000;
            default: a = $random(seed);
         endcase
         send_request(a, pick_access(r[1:0]), pmp_priv_e'(r[2]));
      end
      drain_requests();
      report_test("pipeline", start);
   endtask

   // ----------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------

   initial begin
      int total;
      rst_n      = 1'b0;
      csr_wen    = 1'b0;
      csr_waddr  = 12'h000;
      csr_wdata  = 32'h0;
      csr_raddr  = 12'h000;
      chk_valid  = 1'b0;
      chk_addr   = 32'h0;
      chk_access = acc_read;
      chk_priv   = priv_user;
      clear_model();
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      run_csr_test();
      run_lock_test();
      run_region_test();
      run_priority_test();
      run_pipeline_test();

      @(negedge clk);
      total = errors + u_dut.u_chk.fail_count;
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, checks, errors, u_dut.u_chk.fail_count);
      if (total == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      #(test_cycles * clk_period + margin_ns);
      $display("timeout: tests still running after %0d ns", test_cycles * clk_period + margin_ns);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- project.f
pmp_pkg.sv
pmp_csr_ctrl.sv
pmp_cfg_regs.sv
pmp_region_match.sv
pmp_access_check.sv
pmp_unit.sv
pmp_unit_chk.sv
tb_pmp_unit.sv

//--- Makefile
# Verilator build and run of the PMP unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pmp_unit
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
